/* spi_link_macros.svh */
`ifndef SPI_LINK_MACROS_SVH
`define SPI_LINK_MACROS_SVH

// command codes sent by the io controller as the first byte
`define SPI_CMD_ACK        8'h00
`define SPI_CMD_DATA_IN    8'h10
`define SPI_CMD_CONF_STR   8'h14
`define SPI_CMD_CONFIG     8'h60
`define SPI_CMD_FILE_INFO  8'h56
`define SPI_CMD_PUMP_START 8'h61
`define SPI_CMD_PUMP_END   8'h62

// reply to the ack command, ascii K
`define SPI_ACK_BYTE       8'h4B

// serial byte width
`define SPI_BYTE_W         8

// configuration string length in bytes
`define SPI_CONF_STR_LEN   4

// config slots and download address width
`define SPI_CONFIG_SLOTS   16
`define SPI_IOCTL_ADDR_W   25

// image size reported when a disk image is mounted
`define SPI_DISK_IMG_SIZE  32'd194816

// image index values, disk and tape
`define SPI_IDX_DISK       8'd1
`define SPI_IDX_TAPE       8'd4

`endif

/* spi_link_pkg.sv */
`include "spi_link_macros.svh"

package spi_link_pkg;

	// one serial byte
	typedef logic [`SPI_BYTE_W-1:0] spi_byte_t;

	// framing state of the receiver
	typedef struct packed {
		// command byte of the current transaction
		spi_byte_t  cmd;
		// bit position inside the current byte
		logic [2:0] bit_idx;
		// data byte number, saturates at 255
		logic [7:0] byte_idx;
		// command byte done, data bytes follow
		logic       in_data;
	} rx_frame_t;

	// one completed data byte
	typedef struct packed {
		spi_byte_t  cmd;
		logic [7:0] byte_idx;
		spi_byte_t  data;
		// high for one cycle per data byte
		logic       strobe;
	} rx_beat_t;

	// download write towards the core
	typedef struct packed {
		logic [`SPI_IOCTL_ADDR_W-1:0] ioctl_addr;
		spi_byte_t                    ioctl_dout;
	} ioctl_write_t;

	// config slots, slot 15 filled first
	typedef spi_byte_t [`SPI_CONFIG_SLOTS-1:0] config_buf_t;

	// file extension, "." then three characters
	typedef logic [31:0] file_ext_t;

endpackage

/* spi_deserializer.sv */
`timescale 1ns/100ps
`include "spi_link_macros.svh"

module spi_deserializer
(
	input  logic                    SPI_SCK,
	input  logic                    SPI_SS2,
	input  logic                    SPI_DI,
	output spi_link_pkg::rx_frame_t frame,
	output spi_link_pkg::rx_beat_t  beat
);

	// earlier bits of the byte under way, newest in bit 0
	logic [`SPI_BYTE_W-2:0]  shift_q;
	// whole byte including the bit sampled at this edge
	spi_link_pkg::spi_byte_t rx_byte;
	logic                    byte_done;
	logic                    strobe_q;
	spi_link_pkg::spi_byte_t beat_cmd_q;
	logic [7:0]              beat_idx_q;
	spi_link_pkg::spi_byte_t beat_data_q;

	// msb first, last bit taken straight from the pin
	assign rx_byte   = {shift_q, SPI_DI};
	assign byte_done = (frame.bit_idx == 3'd7);

	// bit and byte framing, cleared while deselected
	always_ff @(posedge SPI_SCK or posedge SPI_SS2)
	begin
		if (SPI_SS2)
		begin
			frame    <= '0;
			strobe_q <= 1'b0;
		end
		else
		begin
			frame.bit_idx <= frame.bit_idx + 3'd1;
			strobe_q      <= 1'b0;
			if (byte_done)
			begin
				if (!frame.in_data)
				begin
					// eighth edge, command latched
					frame.cmd     <= rx_byte;
					frame.in_data <= 1'b1;
				end
				else
				begin
					strobe_q <= 1'b1;
					// stick at 255 on long transfers
					if (frame.byte_idx != 8'hFF)
						frame.byte_idx <= frame.byte_idx + 8'd1;
				end
			end
		end
	end

	// shifter and beat contents
	always_ff @(posedge SPI_SCK)
	begin
		shift_q <= rx_byte[`SPI_BYTE_W-2:0];
		if (byte_done && frame.in_data)
		begin
			beat_cmd_q  <= frame.cmd;
			beat_idx_q  <= frame.byte_idx;
			beat_data_q <= rx_byte;
		end
	end

	assign beat = '{cmd: beat_cmd_q, byte_idx: beat_idx_q, data: beat_data_q, strobe: strobe_q};

	// beat only right after a finished data byte, never before the command
	a_beat_after_cmd: assert property (@(posedge SPI_SCK) disable iff (SPI_SS2)
		beat.strobe |-> (frame.in_data && frame.bit_idx == 3'd0 && frame.byte_idx != 8'd0));

endmodule

/* spi_reply_serializer.sv */
`timescale 1ns/100ps
`include "spi_link_macros.svh"

module spi_reply_serializer
(
	input  logic                                            SPI_SCK,
	input  logic                                            SPI_SS2,
	input  spi_link_pkg::rx_frame_t                         frame,
	input  spi_link_pkg::spi_byte_t                         data_in,
	input  logic                                            menu_in,
	input  spi_link_pkg::spi_byte_t [`SPI_CONF_STR_LEN-1:0] conf_str,
	input  spi_link_pkg::spi_byte_t                         echo,
	output logic                                            SPI_DO
);

	// string byte for the current data byte
	spi_link_pkg::spi_byte_t str_byte;
	// reply chosen for the byte about to start
	spi_link_pkg::spi_byte_t reply_sel;
	// reply bits 6 to 0 held for the rest of the byte
	logic [`SPI_BYTE_W-2:0]  reply_q;
	logic [2:0]              bit_sel;

	// bit 7 goes out first
	assign bit_sel = ~frame.bit_idx;

	// first character sits in the top byte of conf_str
	always_comb
	begin
		str_byte = '0;
		for (int i = 0; i < `SPI_CONF_STR_LEN; i++)
		begin
			if (frame.byte_idx == 8'(i))
				str_byte = conf_str[`SPI_CONF_STR_LEN - 1 - i];
		end
	end

	// per command reply
	always_comb
	begin
		case (frame.cmd)
			`SPI_CMD_ACK:
				reply_sel = `SPI_ACK_BYTE;
			`SPI_CMD_DATA_IN:
				reply_sel = data_in;
			// string hidden while the menu is up
			`SPI_CMD_CONF_STR:
				reply_sel = menu_in ? '0 : str_byte;
			`SPI_CMD_PUMP_START:
				reply_sel = echo;
			default:
				reply_sel = '0;
		endcase
		// zeros while the command itself comes in
		if (!frame.in_data)
			reply_sel = '0;
	end

	// capture at the first falling edge of each byte
	// so later bits do not see data_in or echo move
	always_ff @(negedge SPI_SCK)
	begin
		if (frame.bit_idx == 3'd0)
			reply_q <= reply_sel[`SPI_BYTE_W-2:0];
	end

	// mode 0, change on falling edge
	always_ff @(negedge SPI_SCK or posedge SPI_SS2)
	begin
		if (SPI_SS2)
			SPI_DO <= 1'b0;
		else if (frame.bit_idx == 3'd0)
			SPI_DO <= reply_sel[`SPI_BYTE_W-1];
		else
			SPI_DO <= reply_q[bit_sel];
	end

endmodule

/* config_capture.sv */
`timescale 1ns/100ps
`include "spi_link_macros.svh"

module config_capture
(
	input  logic                      SPI_SCK,
	input  logic                      SPI_SS2,
	input  spi_link_pkg::rx_beat_t    beat,
	input  logic                      menu_in,
	output spi_link_pkg::config_buf_t config_buffer,
	output spi_link_pkg::file_ext_t   file_ext,
	output spi_link_pkg::spi_byte_t   ioctl_index
);

	localparam int SLOT_W = $clog2(`SPI_CONFIG_SLOTS);

	logic [SLOT_W-1:0]         slot_q;
	logic                      cfg_write;
	logic                      ext_write;
	logic                      type_slot;
	spi_link_pkg::config_buf_t config_q = '0;
	spi_link_pkg::file_ext_t   ext_q    = '0;
	spi_link_pkg::spi_byte_t   index_q  = '0;

	assign cfg_write = beat.strobe && (beat.cmd == `SPI_CMD_CONFIG);
	assign ext_write = beat.strobe && (beat.cmd == `SPI_CMD_FILE_INFO);
	// slot 11 carries the first extension letter
	assign type_slot = (slot_q == SLOT_W'(11));

	// slot pointer, back to the top slot each transaction
	always_ff @(posedge SPI_SCK or posedge SPI_SS2)
	begin
		if (SPI_SS2)
			slot_q <= SLOT_W'(`SPI_CONFIG_SLOTS - 1);
		else if (cfg_write)
			slot_q <= slot_q - SLOT_W'(1);
	end

	// config slots, filled downward
	always_ff @(posedge SPI_SCK)
	begin
		if (cfg_write)
			config_q[slot_q] <= beat.data;
	end

	// image type from the extension letter
	// menu closed means rom, index 0
	always_ff @(posedge SPI_SCK)
	begin
		if (!menu_in)
			index_q <= '0;
		else if (cfg_write && type_slot && beat.data == "d")
			index_q <= `SPI_IDX_DISK;
		else if (cfg_write && type_slot && beat.data == "c")
			index_q <= `SPI_IDX_TAPE;
	end

	// extension from the file info block, bytes 7 to 10
	always_ff @(posedge SPI_SCK)
	begin
		if (ext_write)
		begin
			case (beat.byte_idx)
				8'd7:    ext_q[31:24] <= ".";
				8'd8:    ext_q[23:16] <= beat.data;
				8'd9:    ext_q[15:8]  <= beat.data;
				8'd10:   ext_q[7:0]   <= beat.data;
				default: ;
			endcase
		end
	end

	assign config_buffer = config_q;
	assign file_ext      = ext_q;
	assign ioctl_index   = index_q;

	// pointer only steps down from a nonzero slot inside one transaction
	a_slot_no_wrap: assert property (@(posedge SPI_SCK) disable iff (SPI_SS2)
		(slot_q != $past(slot_q)) |-> ($past(slot_q) != '0));

endmodule

/* download_pump.sv */
`timescale 1ns/100ps
`include "spi_link_macros.svh"

module download_pump
(
	input  logic                       SPI_SCK,
	input  logic                       SPI_SS2,
	input  spi_link_pkg::rx_beat_t     beat,
	input  spi_link_pkg::rx_frame_t    frame,
	input  spi_link_pkg::spi_byte_t    ioctl_index,
	output logic                       ioctl_download,
	output logic                       ioctl_wr,
	output spi_link_pkg::ioctl_write_t ioctl,
	output spi_link_pkg::spi_byte_t    echo,
	output logic [1:0]                 img_mounted,
	output logic [31:0]                img_size
);

	logic                         cmd_done;
	logic                         pump_start;
	logic                         pump_end;
	logic                         pump_beat;
	logic                         is_disk;
	logic                         download_q = 1'b0;
	logic [`SPI_IOCTL_ADDR_W-1:0] addr_q     = '0;
	spi_link_pkg::spi_byte_t      echo_q     = '0;
	logic [31:0]                  size_q     = '0;
	spi_link_pkg::ioctl_write_t   ioctl_q;

	// single cycle right after the command byte
	assign cmd_done   = frame.in_data && (frame.bit_idx == 3'd0) && (frame.byte_idx == 8'd0);
	assign pump_start = cmd_done && (frame.cmd == `SPI_CMD_PUMP_START);
	assign pump_end   = cmd_done && (frame.cmd == `SPI_CMD_PUMP_END);
	assign pump_beat  = beat.strobe && (beat.cmd == `SPI_CMD_PUMP_START);
	assign is_disk    = (ioctl_index == `SPI_IDX_DISK);

	// download level, address and image size live across transactions
	always_ff @(posedge SPI_SCK)
	begin
		if (pump_start)
		begin
			download_q <= 1'b1;
			addr_q     <= '0;
		end
		else if (pump_end)
		begin
			download_q <= 1'b0;
			if (is_disk)
				size_q <= `SPI_DISK_IMG_SIZE;
		end
		// one write per pumped byte
		if (pump_beat)
		begin
			addr_q  <= addr_q + `SPI_IOCTL_ADDR_W'(1);
			echo_q  <= beat.data;
			ioctl_q <= '{ioctl_addr: addr_q, ioctl_dout: beat.data};
		end
	end

	// write pulse and mount strobe, dropped on deselect
	always_ff @(posedge SPI_SCK or posedge SPI_SS2)
	begin
		if (SPI_SS2)
		begin
			ioctl_wr    <= 1'b0;
			img_mounted <= 2'b00;
		end
		else
		begin
			ioctl_wr <= pump_beat;
			// drive 0 reports a new disk
			if (pump_end && is_disk)
				img_mounted <= 2'b01;
		end
	end

	assign ioctl_download = download_q;
	assign ioctl          = ioctl_q;
	assign echo           = echo_q;
	assign img_size       = size_q;

	// writes only inside an open download
	a_wr_in_download: assert property (@(posedge SPI_SCK)
		ioctl_wr |-> ioctl_download);

endmodule

/* spi_link_top.sv */
`timescale 1ns/100ps
`include "spi_link_macros.svh"

module spi_link_top
(
	input  logic                                            SPI_SCK,
	input  logic                                            SPI_SS2,
	input  logic                                            SPI_DI,
	input  spi_link_pkg::spi_byte_t                         data_in,
	input  logic                                            menu_in,
	input  spi_link_pkg::spi_byte_t [`SPI_CONF_STR_LEN-1:0] conf_str,
	output logic                                            SPI_DO,
	output spi_link_pkg::config_buf_t                       config_buffer,
	output spi_link_pkg::file_ext_t                         file_ext,
	output spi_link_pkg::spi_byte_t                         ioctl_index,
	output logic                                            ioctl_download,
	output logic                                            ioctl_wr,
	output spi_link_pkg::ioctl_write_t                      ioctl,
	output logic [1:0]                                      img_mounted,
	output logic [31:0]                                     img_size
);

	// framing state, read by the reply side and the pump
	spi_link_pkg::rx_frame_t frame;
	// one beat per completed data byte
	spi_link_pkg::rx_beat_t  beat;
	// last pumped byte back to the controller
	spi_link_pkg::spi_byte_t echo;

	spi_deserializer i_deserializer (
		.SPI_SCK (SPI_SCK),
		.SPI_SS2 (SPI_SS2),
		.SPI_DI  (SPI_DI),
		.frame   (frame),
		.beat    (beat)
	);

	spi_reply_serializer i_reply (
		.SPI_SCK  (SPI_SCK),
		.SPI_SS2  (SPI_SS2),
		.frame    (frame),
		.data_in  (data_in),
		.menu_in  (menu_in),
		.conf_str (conf_str),
		.echo     (echo),
		.SPI_DO   (SPI_DO)
	);

	config_capture i_config (
		.SPI_SCK       (SPI_SCK),
		.SPI_SS2       (SPI_SS2),
		.beat          (beat),
		.menu_in       (menu_in),
		.config_buffer (config_buffer),
		.file_ext      (file_ext),
		.ioctl_index   (ioctl_index)
	);

	download_pump i_pump (
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (SPI_SS2),
		.beat           (beat),
		.frame          (frame),
		.ioctl_index    (ioctl_index),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl          (ioctl),
		.echo           (echo),
		.img_mounted    (img_mounted),
		.img_size       (img_size)
	);

endmodule

/* tb_spi_link_checks.svh */
`ifndef TB_SPI_LINK_CHECKS_SVH
`define TB_SPI_LINK_CHECKS_SVH

// stop the run with a reason
task automatic fail_run(input string reason);
	$display("%s", reason);
	$display("TEST RESULT: FAIL");
	$fatal(1, "simulation stopped on first error");
endtask

task automatic check_byte(input string name, input spi_link_pkg::spi_byte_t exp,
	input spi_link_pkg::spi_byte_t act);
	if (act !== exp)
	begin
		$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		fail_run("byte value differs");
	end
endtask

// address and data of one write pulse
task automatic check_write(input string name, input spi_link_pkg::ioctl_write_t exp,
	input spi_link_pkg::ioctl_write_t act);
	if (act !== exp)
	begin
		$display("[ERROR] %s: expected addr %h dout %h, actual addr %h dout %h",
			name, exp.ioctl_addr, exp.ioctl_dout, act.ioctl_addr, act.ioctl_dout);
		fail_run("download write differs");
	end
endtask

task automatic check_ext(input string name, input spi_link_pkg::file_ext_t exp,
	input spi_link_pkg::file_ext_t act);
	if (act !== exp)
	begin
		$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		fail_run("file extension differs");
	end
endtask

// slot 15 shows up leftmost
task automatic check_config(input string name, input spi_link_pkg::config_buf_t exp,
	input spi_link_pkg::config_buf_t act);
	if (act !== exp)
	begin
		$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		fail_run("config buffer differs");
	end
endtask

task automatic check_size(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp)
	begin
		$display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
		fail_run("image size differs");
	end
endtask

`endif

/* tb_spi_link.sv */
`timescale 1ns/100ps
`include "spi_link_macros.svh"

module tb_spi_link;

	logic                                            SPI_SCK;
	logic                                            SPI_SS2;
	logic                                            SPI_DI;
	spi_link_pkg::spi_byte_t                         data_in;
	logic                                            menu_in;
	spi_link_pkg::spi_byte_t [`SPI_CONF_STR_LEN-1:0] conf_str;
	logic                                            SPI_DO;
	spi_link_pkg::config_buf_t                       config_buffer;
	spi_link_pkg::file_ext_t                         file_ext;
	spi_link_pkg::spi_byte_t                         ioctl_index;
	logic                                            ioctl_download;
	logic                                            ioctl_wr;
	spi_link_pkg::ioctl_write_t                      ioctl;
	logic [1:0]                                      img_mounted;
	logic [31:0]                                     img_size;

	// one entry per test line
	string                   test_name[$];
	logic                    test_menu[$];
	spi_link_pkg::spi_byte_t test_data_in[$];
	spi_link_pkg::spi_byte_t test_cmd[$];
	int                      test_count[$];
	int                      test_start[$];
	string                   test_kind[$];
	logic [127:0]            test_exp[$];
	// payload and expected replies, flat, indexed from test_start
	spi_link_pkg::spi_byte_t pay_val[$];
	bit                      pay_rand[$];
	spi_link_pkg::spi_byte_t exp_reply[$];
	// bytes of the transaction under way
	spi_link_pkg::spi_byte_t tx_bytes[$];
	spi_link_pkg::spi_byte_t rx_bytes[$];
	spi_link_pkg::ioctl_write_t wr_seen[$];
	int                      cycles = 0;
	int                      limit = 0;
	spi_link_pkg::spi_byte_t last_pumped;
	bit                      pumped_before = 0;
	logic [1:0]              mounted_open;

	`include "tb_spi_link_checks.svh"

	spi_link_top i_dut (
		.SPI_SCK        (SPI_SCK),
		.SPI_SS2        (SPI_SS2),
		.SPI_DI         (SPI_DI),
		.data_in        (data_in),
		.menu_in        (menu_in),
		.conf_str       (conf_str),
		.SPI_DO         (SPI_DO),
		.config_buffer  (config_buffer),
		.file_ext       (file_ext),
		.ioctl_index    (ioctl_index),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl          (ioctl),
		.img_mounted    (img_mounted),
		.img_size       (img_size)
	);

	// 8 ns clock
	initial
	begin
		SPI_SCK = 1'b0;
		forever #4 SPI_SCK = ~SPI_SCK;
	end

	always @(posedge SPI_SCK)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit)
			fail_run($sformatf("timeout after %0d cycles, the tests did not finish", cycles));
	end

	// write pulses are stable at the falling edge
	always @(negedge SPI_SCK)
	begin
		if (ioctl_wr === 1'b1)
			wr_seen.push_back(ioctl);
	end

	task automatic read_tests();
		int    fd;
		int    r;
		int    n;
		int    total;
		int    v;
		string tok;
		string line;
		logic [127:0] ev;
		begin
			total = 0;
			fd = $fopen("spi_link_tests.txt", "r");
			if (fd == 0)
				fail_run("could not open spi_link_tests.txt");
			while (!$feof(fd))
			begin
				r = $fscanf(fd, "%s", tok);
				if (r != 1)
					break;
				// comment lines
				if (tok.substr(0, 0) == "#")
				begin
					r = $fgets(line, fd);
					continue;
				end
				test_name.push_back(tok);
				r = $fscanf(fd, "%h", v);
				test_menu.push_back(v[0]);
				r = $fscanf(fd, "%h", v);
				test_data_in.push_back(v[7:0]);
				r = $fscanf(fd, "%h", v);
				test_cmd.push_back(v[7:0]);
				r = $fscanf(fd, "%d", n);
				test_count.push_back(n);
				test_start.push_back(pay_val.size());
				for (int i = 0; i < n; i++)
				begin
					r = $fscanf(fd, "%s", tok);
					v = 0;
					if (tok != "rand")
						r = $sscanf(tok, "%h", v);
					pay_rand.push_back(tok == "rand");
					pay_val.push_back(v[7:0]);
				end
				r = $fscanf(fd, "%s", tok);
				test_kind.push_back(tok);
				ev = '0;
				// reply lines carry one byte per payload byte
				for (int i = 0; i < n; i++)
				begin
					v = 0;
					if (tok == "reply")
						r = $fscanf(fd, "%h", v);
					exp_reply.push_back(v[7:0]);
				end
				if (tok != "reply")
					r = $fscanf(fd, "%h", ev);
				test_exp.push_back(ev);
				total += n + 1;
			end
			$fclose(fd);
			limit = 2 * total * 8 + 200;
		end
	endtask

	// msb first, input changes 1 ns after the rising edge
	task automatic send_byte(input spi_link_pkg::spi_byte_t tx,
		output spi_link_pkg::spi_byte_t rx);
		for (int i = 7; i >= 0; i--)
		begin
			SPI_DI = tx[i];
			@(posedge SPI_SCK);
			rx[i] = SPI_DO;
			#1;
		end
	endtask

	task automatic do_transaction();
		spi_link_pkg::spi_byte_t b;
		begin
			@(posedge SPI_SCK);
			#1;
			SPI_SS2 = 1'b0;
			rx_bytes.delete();
			foreach (tx_bytes[i])
			begin
				send_byte(tx_bytes[i], b);
				rx_bytes.push_back(b);
			end
			// two more edges so the last beat lands
			SPI_DI = 1'b0;
			@(posedge SPI_SCK);
			@(posedge SPI_SCK);
			#0.5;
			mounted_open = img_mounted;
			#0.5;
			SPI_SS2 = 1'b1;
			repeat (2) @(posedge SPI_SCK);
			#1;
		end
	endtask

	task automatic run_test(input int t);
		int                         base;
		int                         n;
		string                      name;
		logic [127:0]               ev;
		spi_link_pkg::ioctl_write_t exp_wr;
		begin
			base = test_start[t];
			n    = test_count[t];
			name = test_name[t];
			ev   = test_exp[t];
			menu_in = test_menu[t];
			data_in = test_data_in[t];
			tx_bytes.delete();
			tx_bytes.push_back(test_cmd[t]);
			for (int i = 0; i < n; i++)
			begin
				if (pay_rand[base + i])
					tx_bytes.push_back(8'($urandom));
				else
					tx_bytes.push_back(pay_val[base + i]);
			end
			wr_seen.delete();
			do_transaction();
			// nothing comes back while the command goes out
			check_byte(name, 8'h00, rx_bytes[0]);
			if (test_kind[t] == "reply")
			begin
				for (int i = 0; i < n; i++)
					check_byte(name, exp_reply[base + i], rx_bytes[i + 1]);
			end
			else if (test_kind[t] == "config")
				check_config(name, ev, config_buffer);
			else if (test_kind[t] == "index")
				check_byte(name, ev[7:0], ioctl_index);
			else if (test_kind[t] == "ext")
				check_ext(name, ev[31:0], file_ext);
			else if (test_kind[t] == "pump")
			begin
				check_byte(name, ev[7:0], {7'b0, ioctl_download});
				if (wr_seen.size() != n)
					fail_run($sformatf("%s: saw %0d write pulses for %0d bytes",
						name, wr_seen.size(), n));
				for (int i = 0; i < n; i++)
				begin
					exp_wr = '{ioctl_addr: `SPI_IOCTL_ADDR_W'(i), ioctl_dout: tx_bytes[i + 1]};
					check_write(name, exp_wr, wr_seen[i]);
				end
				// first reply byte echoes the previous pump
				if (pumped_before && n > 0)
					check_byte(name, last_pumped, rx_bytes[1]);
				if (n > 0)
				begin
					last_pumped   = tx_bytes[n];
					pumped_before = 1'b1;
				end
			end
			else if (test_kind[t] == "mount")
			begin
				check_byte(name, 8'h00, {7'b0, ioctl_download});
				check_byte(name, 8'h01, {6'b0, mounted_open});
				check_byte(name, 8'h00, {6'b0, img_mounted});
				check_size(name, ev[31:0], img_size);
			end
			else
				fail_run($sformatf("%s: unknown check kind %s", name, test_kind[t]));
		end
	endtask

	initial
	begin
		SPI_SS2  = 1'b1;
		SPI_DI   = 1'b0;
		data_in  = '0;
		menu_in  = 1'b0;
		conf_str = "ABCD";
		void'($urandom(49166));
		read_tests();
		// deselect doubles as reset
		repeat (16) @(posedge SPI_SCK);
		#1;
		for (int t = 0; t < test_name.size(); t++)
			run_test(t);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* spi_link_tests.txt */
# name menu_in data_in cmd count payload... kind expected
# reply lists one byte per payload byte, other kinds one hex value
ack 0 00 00 4 00 00 00 00 reply 4b 4b 4b 4b
data_in 0 3c 10 3 00 00 00 reply 3c 3c 3c
conf_str 0 00 14 6 00 00 00 00 00 00 reply 41 42 43 44 00 00
conf_str_menu 1 00 14 5 00 00 00 00 00 reply 00 00 00 00 00
cfg_tape 1 00 60 15 00 01 02 03 63 05 06 07 08 09 0a 0b 0c 0d 0e config 000102036305060708090a0b0c0d0e00
idx_tape 1 00 00 0 index 04
cfg_disk 1 00 60 15 10 11 12 13 64 15 16 17 18 19 1a 1b 1c 1d 1e config 101112136415161718191a1b1c1d1e00
idx_disk 1 00 00 0 index 01
file_ext 1 00 56 11 00 01 02 03 04 05 06 07 72 6f 6d ext 2e726f6d
pump_first 1 00 61 6 rand rand rand rand rand rand pump 1
pump_echo 1 00 61 4 rand rand rand rand pump 1
pump_end 1 00 62 0 mount 2f900
idx_menu_off 0 00 00 0 index 00

/* src.f */
+incdir+.
spi_link_pkg.sv
spi_deserializer.sv
spi_reply_serializer.sv
config_capture.sv
download_pump.sv
spi_link_top.sv
tb_spi_link.sv

/* Makefile */
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module spi_link_top
	verilator --lint-only --timing -f src.f --top-module tb_spi_link

sim:
	verilator --binary --timing --assert -f src.f --top-module tb_spi_link
	-./obj_dir/Vtb_spi_link > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
